// File: list.f
common/mem_pipe_pkg.sv
logic/mem1_stage.sv
logic/data_ram.sv
mem_stage/mem_stage.sv
logic/wb_stage.sv
logic/mem_pipe_top.sv
test/mem_pipe_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = mem_pipe_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/mem_pipe_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_pipe_tb import mem_pipe_pkg::*; ();

    localparam int NUM_ROWS   = 40;
    localparam int MAX_BUSY   = 3;
    localparam int MAX_GAP    = 2;
    localparam int RST_CYCLES = 10;
    // worst case every row gapped and stalled, plus register readback
    localparam int CYCLE_LIMIT = RST_CYCLES + NUM_ROWS * (4 + MAX_BUSY + MAX_GAP) + 2 * 32 + 50;

    typedef struct packed {
        m1_op_t op;
        logic   busy;      // stall the cache after this row is accepted
        word_t  exp_data;
        logic   exp_we;
    } row_t;

    logic     clk;
    logic     reset;
    logic     in_valid;
    m1_op_t   in_op;
    logic     in_allowin;
    logic     dcache_busy;
    reg_idx_t fwd_dest;
    word_t    fwd_result;
    logic     retire_valid;
    word_t    retire_pc;
    reg_idx_t retire_dest;
    word_t    retire_data;
    logic     retire_we;
    reg_idx_t rf_raddr;
    word_t    rf_rdata;

    row_t     rows [NUM_ROWS];
    word_t    ref_mem [256];
    word_t    ref_rf [32];
    int       n_rows = 0;
    int       seed = 55;
    int       cycle = 0;
    int       ret_idx = 0;
    int       busy_left = 0;
    int       busy_seen = 0;   // busy cycles seen so far
    int       acc_cycle [$];
    int       acc_busy [$];
    reg_idx_t last_fwd_dest = '0;
    word_t    last_fwd_result = '0;
    int       checks = 0;
    int       value_errs = 0;
    int       other_errs = 0;

    mem_pipe_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_allowin   (in_allowin),
        .dcache_busy  (dcache_busy),
        .fwd_dest     (fwd_dest),
        .fwd_result   (fwd_result),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_dest  (retire_dest),
        .retire_data  (retire_data),
        .retire_we    (retire_we),
        .rf_raddr     (rf_raddr),
        .rf_rdata     (rf_rdata)
    );

    always #20 clk = ~clk;

    // reference model runs in program order while the table is built
    task automatic add_row(input mem_op_e op, input word_t addr, input word_t rt,
                           input reg_idx_t dest, input logic ex, input logic mfc0,
                           input word_t cp0, input logic busy);
        row_t        r;
        word_t       w;
        word_t       res;
        int          a;
        int          o;
        int          s;
        logic [7:0]  b;
        logic [15:0] h;
        a = int'(addr[9:2]);
        o = int'(addr[1:0]);
        w = ref_mem[a];
        b = w[8*o +: 8];
        case (o)
            0:       h = w[15:0];
            2:       h = w[31:16];
            default: h = '0;
        endcase
        res = mfc0 ? cp0 : addr;  // anything that is not a load
        case (op)
            op_lw:  res = w;
            op_lb:  res = {{24{b[7]}}, b};
            op_lbu: res = {24'h0, b};
            op_lh:  res = {{16{h[15]}}, h};
            op_lhu: res = {16'h0, h};
            op_lwl: begin
                s   = 8 * (3 - o);  // bytes up to the offset land on top
                res = (w << s) | (rt & ~(32'hffff_ffff << s));
            end
            op_lwr: begin
                s   = 8 * o;
                res = (w >> s) | (rt & ~(32'hffff_ffff >> s));
            end
            op_sb: if (!ex) ref_mem[a][8*o +: 8] = rt[7:0];
            op_sh: if (!ex) ref_mem[a][16*(o/2) +: 16] = rt[15:0];
            op_sw: if (!ex) ref_mem[a] = rt;
            default: ;
        endcase
        r               = '0;
        r.op.ex         = ex;
        r.op.mfc0       = mfc0;
        r.op.cp0_data   = cp0;
        r.op.rt_value   = rt;
        r.op.mem_op     = op;
        r.op.gr_we      = !(op inside {op_sw, op_sh, op_sb});
        r.op.dest       = dest;
        r.op.alu_result = addr;
        r.op.pc         = 32'h0000_1000 + 4 * n_rows;
        r.busy          = busy;
        r.exp_data      = res;
        r.exp_we        = r.op.gr_we && !ex;
        if (r.exp_we && dest != '0) ref_rf[dest] = res;
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic build_table;
        add_row(op_sw,   32'h0000_0100, 32'h8421_c3f5, 5'd0,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_sh,   32'h0000_0104, 32'h0000_a5b6, 5'd0,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_sh,   32'h0000_0106, 32'h1234_7c01, 5'd0,  1'b0, 1'b0, 32'h0, 1'b1);
        add_row(op_sb,   32'h0000_0108, 32'h0000_00f1, 5'd0,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_sb,   32'h0000_0109, 32'h0000_0022, 5'd0,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_sb,   32'h0000_010a, 32'h0000_0083, 5'd0,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_sb,   32'h0000_010b, 32'h0000_0044, 5'd0,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lw,   32'h0000_0100, 32'h0,         5'd1,  1'b0, 1'b0, 32'h0, 1'b1);
        add_row(op_lb,   32'h0000_0100, 32'h0,         5'd2,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lb,   32'h0000_0101, 32'h0,         5'd3,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lb,   32'h0000_0102, 32'h0,         5'd4,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lb,   32'h0000_0103, 32'h0,         5'd5,  1'b0, 1'b0, 32'h0, 1'b1);
        add_row(op_lbu,  32'h0000_0108, 32'h0,         5'd6,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lbu,  32'h0000_0109, 32'h0,         5'd7,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lbu,  32'h0000_010a, 32'h0,         5'd8,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lbu,  32'h0000_010b, 32'h0,         5'd9,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lh,   32'h0000_0104, 32'h0,         5'd10, 1'b0, 1'b0, 32'h0, 1'b1);
        add_row(op_lh,   32'h0000_0106, 32'h0,         5'd11, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lhu,  32'h0000_0100, 32'h0,         5'd12, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lhu,  32'h0000_0102, 32'h0,         5'd13, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lw,   32'h0000_0108, 32'h0,         5'd14, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lwl,  32'h0000_0100, 32'hdead_beef, 5'd15, 1'b0, 1'b0, 32'h0, 1'b1);
        add_row(op_lwl,  32'h0000_0101, 32'hdead_beef, 5'd16, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lwl,  32'h0000_0102, 32'hdead_beef, 5'd17, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lwl,  32'h0000_0103, 32'hdead_beef, 5'd18, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lwr,  32'h0000_0104, 32'h0bad_cafe, 5'd19, 1'b0, 1'b0, 32'h0, 1'b1);
        add_row(op_lwr,  32'h0000_0105, 32'h0bad_cafe, 5'd20, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lwr,  32'h0000_0106, 32'h0bad_cafe, 5'd21, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lwr,  32'h0000_0107, 32'h0bad_cafe, 5'd22, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_none, 32'h1357_9bdf, 32'h0,         5'd23, 1'b0, 1'b0, 32'h0, 1'b1);
        add_row(op_none, 32'h0000_0040, 32'h0,         5'd24, 1'b0, 1'b1, 32'hc0de_0001, 1'b0);
        add_row(op_sw,   32'h0000_0100, 32'hffff_ffff, 5'd0,  1'b1, 1'b0, 32'h0, 1'b0);
        add_row(op_lw,   32'h0000_0104, 32'h0,         5'd25, 1'b1, 1'b0, 32'h0, 1'b1);
        add_row(op_none, 32'h0000_7777, 32'h0,         5'd26, 1'b1, 1'b0, 32'h0, 1'b0);
        add_row(op_lw,   32'h0000_0100, 32'h0,         5'd27, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_sw,   32'h0000_010c, 32'h0f0f_5a5a, 5'd0,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lw,   32'h0000_010c, 32'h0,         5'd28, 1'b0, 1'b0, 32'h0, 1'b1);
        add_row(op_none, 32'h0000_0055, 32'h0,         5'd0,  1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_lb,   32'h0000_010d, 32'h0,         5'd29, 1'b0, 1'b0, 32'h0, 1'b0);
        add_row(op_none, 32'h0000_2468, 32'h0,         5'd1,  1'b0, 1'b0, 32'h0, 1'b0);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t got);
        checks++;
        assert (got === exp) else begin
            value_errs++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_retire;
        row_t r;
        int   lat;
        int   busy0;
        r     = rows[ret_idx];
        lat   = cycle - acc_cycle.pop_front();
        busy0 = acc_busy.pop_front();
        check_word("retire_pc", r.op.pc, retire_pc);
        check_word("retire_dest", word_t'(r.op.dest), word_t'(retire_dest));
        check_word("retire_data", r.exp_data, retire_data);
        check_word("retire_we", word_t'(r.exp_we), word_t'(retire_we));
        check_word("fwd_dest", word_t'(r.op.dest), word_t'(last_fwd_dest));
        check_word("fwd_result", r.exp_data, last_fwd_result);
        checks++;
        // three edges from acceptance when no busy cycle hit the flight
        assert (busy_seen == busy0 ? lat == 3 : lat >= 3) else begin
            other_errs++;
            $display("ERROR t=%0t: pc %h retired %0d cycles after it was accepted",
                     $time, r.op.pc, lat);
        end
        ret_idx++;
    endtask

    task automatic end_run;
        $display("retired %0d of %0d, %0d checks, %0d value errors, %0d other errors",
                 ret_idx, NUM_ROWS, checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // retire, forwarding and acceptance monitor
    always @(posedge clk) begin
        cycle++;
        if (!reset) begin
            if (retire_valid) begin
                checks++;
                assert (ret_idx < NUM_ROWS && acc_cycle.size() > 0) else begin
                    other_errs++;
                    $display("ERROR t=%0t: retire seen with no instruction outstanding", $time);
                end
                if (ret_idx < NUM_ROWS && acc_cycle.size() > 0) check_retire();
            end else begin
                check_word("fwd_dest", 32'h0, word_t'(last_fwd_dest));  // nothing handed on
            end
            busy_seen += dcache_busy ? 1 : 0;
            if (in_valid && in_allowin) begin
                acc_cycle.push_back(cycle);
                acc_busy.push_back(busy_seen);
            end
            last_fwd_dest   = fwd_dest;
            last_fwd_result = fwd_result;
        end
    end

    always @(negedge clk) begin
        if (busy_left > 0) begin
            dcache_busy = 1'b1;
            busy_left--;
        end else begin
            dcache_busy = 1'b0;
        end
    end

    initial begin
        int   r;
        int   gap;
        logic took;
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_op       = '0;
        dcache_busy = 1'b0;
        rf_raddr    = '0;
        for (int k = 0; k < 32; k++) ref_rf[k] = '0;
        build_table();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        check_word("in_allowin", 32'h1, word_t'(in_allowin));
        check_word("retire_valid", 32'h0, word_t'(retire_valid));
        check_word("fwd_dest", 32'h0, word_t'(fwd_dest));
        check_word("ram_en", 32'h0, word_t'(dut_i.ram_en));
        check_word("ram_we", 32'h0, word_t'(dut_i.ram_we));
        for (int i = 0; i < NUM_ROWS; i++) begin
            r   = $random(seed);
            gap = ((r & 15) < 4) ? 1 + ((r >> 4) & 1) : 0;
            @(negedge clk);
            repeat (gap) begin
                in_valid = 1'b0;
                @(negedge clk);
            end
            in_valid = 1'b1;
            in_op    = rows[i].op;
            do begin
                @(posedge clk);
                took = in_allowin;  // held until the pipe takes it
            end while (!took);
            if (rows[i].busy) busy_left = 1 + ((r >> 8) & 3) % MAX_BUSY;
        end
        @(negedge clk);
        in_valid = 1'b0;
        while (ret_idx < NUM_ROWS) @(negedge clk);
        repeat (3) @(negedge clk);
        for (int k = 0; k < 32; k++) begin
            rf_raddr = reg_idx_t'(k);
            @(posedge clk);
            check_word($sformatf("rf_rdata[%0d]", k), ref_rf[k], rf_rdata);
            @(negedge clk);
        end
        end_run();
    end

    initial begin
        wait (cycle >= CYCLE_LIMIT);
        other_errs++;
        $display("ERROR: run did not finish within %0d cycles and was stopped", CYCLE_LIMIT);
        end_run();
    end

endmodule

`default_nettype wire

// File: logic/mem_pipe_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_pipe_top import mem_pipe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  m1_op_t   in_op,
    output logic     in_allowin,
    input  logic     dcache_busy,
    output reg_idx_t fwd_dest,
    output word_t    fwd_result,
    output logic     retire_valid,
    output word_t    retire_pc,
    output reg_idx_t retire_dest,
    output word_t    retire_data,
    output logic     retire_we,
    input  reg_idx_t rf_raddr,
    output word_t    rf_rdata
);

    logic      m1_to_ms_valid;
    ms_op_t    m1_to_ms_op;
    logic      ms_allowin;
    logic      ms_to_ws_valid;
    wb_op_t    ms_to_ws_op;
    logic      ws_allowin;
    logic      ram_en;
    byte_en_t  ram_we;
    ram_addr_t ram_addr;
    word_t     ram_wdata;
    word_t     ram_rdata;

    mem1_stage mem1_stage_i (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_op          (in_op),
        .in_allowin     (in_allowin),
        .ms_allowin     (ms_allowin),
        .m1_to_ms_valid (m1_to_ms_valid),
        .m1_to_ms_op    (m1_to_ms_op),
        .ram_en         (ram_en),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata)
    );

    data_ram data_ram_i (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_stage mem_stage_i (
        .clk            (clk),
        .reset          (reset),
        .m1_to_ms_valid (m1_to_ms_valid),
        .m1_to_ms_op    (m1_to_ms_op),
        .ms_allowin     (ms_allowin),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_op    (ms_to_ws_op),
        .data_rdata     (ram_rdata),
        .dcache_busy    (dcache_busy),
        .fwd_dest       (fwd_dest),
        .fwd_result     (fwd_result)
    );

    wb_stage wb_stage_i (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_op    (ms_to_ws_op),
        .ws_allowin     (ws_allowin),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_dest    (retire_dest),
        .retire_data    (retire_data),
        .retire_we      (retire_we),
        .rf_raddr       (rf_raddr),
        .rf_rdata       (rf_rdata)
    );

endmodule

`default_nettype wire

// File: logic/wb_stage.sv
`timescale 1ns/100ps
`default_nettype none

module wb_stage import mem_pipe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     ms_to_ws_valid,
    input  wb_op_t   ms_to_ws_op,
    output logic     ws_allowin,
    output logic     retire_valid,
    output word_t    retire_pc,
    output reg_idx_t retire_dest,
    output word_t    retire_data,
    output logic     retire_we,
    input  reg_idx_t rf_raddr,
    output word_t    rf_rdata
);

    logic   ws_valid;
    wb_op_t ws_op;
    word_t  rf [32];

    assign ws_allowin = 1'b1;  // last stage never stalls

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_op <= ms_to_ws_op;
        end
    end

    assign retire_valid = ws_valid;
    assign retire_pc    = ws_op.pc;
    assign retire_dest  = ws_op.dest;
    assign retire_data  = ws_op.result;
    assign retire_we    = ws_op.gr_we && !ws_op.ex;

    // architectural registers start from zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (retire_valid && retire_we && retire_dest != '0) begin
            rf[retire_dest] <= retire_data;
        end
    end

    assign rf_rdata = (rf_raddr == '0) ? '0 : rf[rf_raddr];  // r0 hardwired

endmodule

`default_nettype wire

// File: mem_stage/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage import mem_pipe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     m1_to_ms_valid,
    input  ms_op_t   m1_to_ms_op,
    output logic     ms_allowin,
    input  logic     ws_allowin,
    output logic     ms_to_ws_valid,
    output wb_op_t   ms_to_ws_op,
    input  word_t    data_rdata,
    input  logic     dcache_busy,
    output reg_idx_t fwd_dest,
    output word_t    fwd_result
);

    logic         ms_valid;
    logic         ms_ready_go;
    ms_op_t       ms_op;
    logic [1:0]   ofs;
    logic [7:0]   ld_byte;
    logic [15:0]  ld_half;
    word_t        rt;
    word_t        load_data;
    word_t        final_result;

    assign ms_ready_go    = !dcache_busy;  // hold the item while cache is busy
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= m1_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (m1_to_ms_valid && ms_allowin) begin
            ms_op <= m1_to_ms_op;
        end
    end

    assign ofs = ms_op.alu_result[1:0];
    assign rt  = ms_op.rt_value;

    always_comb begin
        case (ofs)
            2'd0:    ld_byte = data_rdata[7:0];
            2'd1:    ld_byte = data_rdata[15:8];
            2'd2:    ld_byte = data_rdata[23:16];
            default: ld_byte = data_rdata[31:24];
        endcase
    end

    // misaligned halfword reads as zero
    always_comb begin
        case (ofs)
            2'd0:    ld_half = data_rdata[15:0];
            2'd2:    ld_half = data_rdata[31:16];
            default: ld_half = '0;
        endcase
    end

    always_comb begin
        load_data = data_rdata;  // lw
        case (ms_op.mem_op)
            op_lb:  load_data = {{24{ld_byte[7]}}, ld_byte};
            op_lbu: load_data = {24'd0, ld_byte};
            op_lh:  load_data = {{16{ld_half[15]}}, ld_half};
            op_lhu: load_data = {16'd0, ld_half};
            op_lwl: begin
                case (ofs)  // memory bytes fill from the top
                    2'd0:    load_data = {data_rdata[7:0], rt[23:0]};
                    2'd1:    load_data = {data_rdata[15:0], rt[15:0]};
                    2'd2:    load_data = {data_rdata[23:0], rt[7:0]};
                    default: load_data = data_rdata;
                endcase
            end
            op_lwr: begin
                case (ofs)  // memory bytes fill from the bottom
                    2'd0:    load_data = data_rdata;
                    2'd1:    load_data = {rt[31:24], data_rdata[31:8]};
                    2'd2:    load_data = {rt[31:16], data_rdata[31:16]};
                    default: load_data = {rt[31:8], data_rdata[31:24]};
                endcase
            end
            default: load_data = data_rdata;
        endcase
    end

    assign final_result = is_load(ms_op.mem_op) ? load_data :
                          ms_op.mfc0            ? ms_op.cp0_data :
                                                  ms_op.alu_result;

    assign ms_to_ws_op = '{
        ex:     ms_op.ex,
        gr_we:  ms_op.gr_we,
        dest:   ms_op.dest,
        result: final_result,
        pc:     ms_op.pc
    };

    // bypass to decode, no dest while stalled or empty
    assign fwd_dest   = ms_to_ws_valid ? ms_op.dest : '0;
    assign fwd_result = final_result;

endmodule

`default_nettype wire

// File: logic/data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module data_ram import mem_pipe_pkg::*; (
    input  logic      clk,
    input  logic      en,
    input  byte_en_t  we,
    input  ram_addr_t addr,
    input  word_t     wdata,
    output word_t     rdata
);

    word_t mem_array [1 << RAM_ADDR_W];

    // read returns the old word, rdata only moves on an enabled access
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem_array[addr];
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem_array[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/mem1_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem1_stage import mem_pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  m1_op_t    in_op,
    output logic      in_allowin,
    input  logic      ms_allowin,
    output logic      m1_to_ms_valid,
    output ms_op_t    m1_to_ms_op,
    output logic      ram_en,
    output byte_en_t  ram_we,
    output ram_addr_t ram_addr,
    output word_t     ram_wdata
);

    logic     m1_valid;
    ms_op_t   m1_op;
    logic     m1_go;     // item moves into mem stage this edge
    logic     st_ok;
    byte_en_t lane_we;

    assign in_allowin     = !m1_valid || ms_allowin;
    assign m1_to_ms_valid = m1_valid;  // ram access is issued on the handoff edge
    assign m1_to_ms_op    = m1_op;
    assign m1_go          = m1_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            m1_valid <= 1'b0;
        end else if (in_allowin) begin
            m1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            m1_op <= in_op;
        end
    end

    // exception blocks the write, loads still read harmlessly
    assign st_ok    = m1_go && is_store(m1_op.mem_op) && !m1_op.ex;
    assign ram_en   = (m1_go && is_load(m1_op.mem_op)) || st_ok;
    assign ram_addr = m1_op.alu_result[RAM_ADDR_W+1:2];

    // lane enables from the low address bits, data repeated across lanes
    always_comb begin
        lane_we   = '0;
        ram_wdata = m1_op.rt_value;
        case (m1_op.mem_op)
            op_sb: begin
                lane_we   = byte_en_t'(4'b0001 << m1_op.alu_result[1:0]);
                ram_wdata = {4{m1_op.rt_value[7:0]}};
            end
            op_sh: begin
                lane_we   = m1_op.alu_result[1] ? 4'b1100 : 4'b0011;
                ram_wdata = {2{m1_op.rt_value[15:0]}};
            end
            op_sw:   lane_we = 4'b1111;
            default: lane_we = '0;
        endcase
    end

    assign ram_we = st_ok ? lane_we : '0;

endmodule

`default_nettype wire

// File: common/mem_pipe_pkg.sv
`default_nettype none

package mem_pipe_pkg;

    localparam int RAM_ADDR_W = 8;  // 256 words of data ram

    typedef logic [31:0]           word_t;
    typedef logic [4:0]            reg_idx_t;
    typedef logic [3:0]            byte_en_t;
    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

    typedef enum logic [3:0] {
        op_none,
        op_lw,
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lwl,
        op_lwr,
        op_sw,
        op_sh,
        op_sb
    } mem_op_e;

    // decoded and executed instruction entering mem1
    typedef struct packed {
        logic     ex;          // exception seen upstream
        logic     mfc0;        // result comes from cp0
        word_t    cp0_data;
        word_t    rt_value;    // store data, lwl/lwr merge source
        mem_op_e  mem_op;
        logic     gr_we;
        reg_idx_t dest;
        word_t    alu_result;  // effective address for memory ops
        word_t    pc;
    } m1_op_t;

    typedef m1_op_t ms_op_t;  // mem1 to mem

    typedef struct packed {
        logic     ex;
        logic     gr_we;
        reg_idx_t dest;
        word_t    result;
        word_t    pc;
    } wb_op_t;

    function automatic logic is_load(mem_op_e op);
        return (op inside {op_lw, op_lb, op_lbu, op_lh, op_lhu, op_lwl, op_lwr});
    endfunction

    function automatic logic is_store(mem_op_e op);
        return (op inside {op_sw, op_sh, op_sb});
    endfunction

endpackage

`default_nettype wire
